// File: project.f
rtl/axi_wr_pkg.sv
rtl/skid_buffer.sv
rtl/rr_arbiter.sv
rtl/axi_wr_arbiter.sv
rtl/axi_wr_memory.sv
rtl/axi_wr_subsystem.sv
sim/axi_wr_assertions.sv
sim/axi_wr_tb.sv

// File: rtl/axi_wr_arbiter.sv
`timescale 1ns/1ns

module axi_wr_arbiter (
  input  logic                                           clk,
  input  logic                                           rst_n,

  // manager ports
  input  logic              [axi_wr_pkg::num_m-1:0]      i_awvalid,
  input  axi_wr_pkg::addr_t [axi_wr_pkg::num_m-1:0]      i_awaddr,
  input  axi_wr_pkg::id_t   [axi_wr_pkg::num_m-1:0]      i_awid,
  input  axi_wr_pkg::len_t  [axi_wr_pkg::num_m-1:0]      i_awlen,
  input  axi_wr_pkg::size_t [axi_wr_pkg::num_m-1:0]      i_awsize,
  input  axi_wr_pkg::burst_t [axi_wr_pkg::num_m-1:0]     i_awburst,
  output logic              [axi_wr_pkg::num_m-1:0]      o_awready,
  input  logic              [axi_wr_pkg::num_m-1:0]      i_wvalid,
  input  axi_wr_pkg::data_t [axi_wr_pkg::num_m-1:0]      i_wdata,
  input  axi_wr_pkg::strb_t [axi_wr_pkg::num_m-1:0]      i_wstrb,
  input  logic              [axi_wr_pkg::num_m-1:0]      i_wlast,
  output logic              [axi_wr_pkg::num_m-1:0]      o_wready,
  output logic              [axi_wr_pkg::num_m-1:0]      o_bvalid,
  output axi_wr_pkg::id_t   [axi_wr_pkg::num_m-1:0]      o_bid,
  output axi_wr_pkg::resp_t [axi_wr_pkg::num_m-1:0]      o_bresp,
  input  logic              [axi_wr_pkg::num_m-1:0]      i_bready,

  // subordinate port
  output axi_wr_pkg::aw_t                                o_aw,
  output logic                                           o_aw_valid,
  input  logic                                           i_aw_ready,
  output axi_wr_pkg::w_t                                 o_w,
  output logic                                           o_w_valid,
  input  logic                                           i_w_ready,
  input  axi_wr_pkg::b_t                                 i_b,
  input  logic                                           i_b_valid,
  output logic                                           o_b_ready
);

  import axi_wr_pkg::*;

  logic [aw_req_w-1:0] sb_aw [num_m];
  logic [num_m-1:0]    sb_awvalid;
  logic [num_m-1:0]    sb_awready;
  w_t                  sb_w [num_m];
  logic [num_m-1:0]    sb_wvalid;
  logic [num_m-1:0]    sb_wready;
  logic [num_m-1:0]    sb_bready;

  logic                grant_valid;
  idx_t                grant_idx;
  logic                grant_done;
  logic                aw_accepted;
  id_t                 aw_id;

  idx_t                b_idx;
  id_t                 b_id;

  // ----------------------------------------------------------------------
  // per-manager buffers
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < num_m; i++) begin : gen_m
    skid_buffer #(
      .width(aw_req_w)
    ) aw_buf (
      .clk    (clk),
      .rst_n  (rst_n),
      .i_valid(i_awvalid[i]),
      .i_data ({i_awid[i], i_awaddr[i], i_awlen[i], i_awsize[i], i_awburst[i]}),
      .o_ready(o_awready[i]),
      .o_valid(sb_awvalid[i]),
      .o_data (sb_aw[i]),
      .i_ready(sb_awready[i])
    );

    skid_buffer #(
      .width($bits(w_t))
    ) w_buf (
      .clk    (clk),
      .rst_n  (rst_n),
      .i_valid(i_wvalid[i]),
      .i_data ({i_wdata[i], i_wstrb[i], i_wlast[i]}),
      .o_ready(o_wready[i]),
      .o_valid(sb_wvalid[i]),
      .o_data (sb_w[i]),
      .i_ready(sb_wready[i])
    );

    // responses are steered here by the index in the upper id bits
    skid_buffer #(
      .width(b_rsp_w)
    ) b_buf (
      .clk    (clk),
      .rst_n  (rst_n),
      .i_valid(i_b_valid && (b_idx == idx_t'(i))),
      .i_data ({b_id, i_b.resp}),
      .o_ready(sb_bready[i]),
      .o_valid(o_bvalid[i]),
      .o_data ({o_bid[i], o_bresp[i]}),
      .i_ready(i_bready[i])
    );
  end

  // ----------------------------------------------------------------------
  // grant, held from address to last data beat
  // ----------------------------------------------------------------------
  assign grant_done = o_w_valid && i_w_ready && o_w.last;

  rr_arbiter arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_request    (sb_awvalid),
    .i_done       (grant_done),
    .o_grant_valid(grant_valid),
    .o_grant_idx  (grant_idx)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_accepted <= 1'b0;
    end else if (o_aw_valid && i_aw_ready) begin
      aw_accepted <= 1'b1;
    end else if (grant_done) begin
      aw_accepted <= 1'b0;
    end
  end

  // address mux, id gets the manager index on top
  assign o_aw_valid = grant_valid && !aw_accepted;

  always_comb begin
    {aw_id, o_aw.addr, o_aw.len, o_aw.size, o_aw.burst} = sb_aw[grant_idx];
    o_aw.id = {grant_idx, aw_id};
  end

  // data only flows once its address has gone out
  assign o_w       = sb_w[grant_idx];
  assign o_w_valid = grant_valid && aw_accepted && sb_wvalid[grant_idx];

  always_comb begin
    sb_awready = '0;
    sb_wready  = '0;
    if (grant_valid) begin
      sb_awready[grant_idx] = i_aw_ready && !aw_accepted;
      sb_wready[grant_idx]  = i_w_ready && aw_accepted;
    end
  end

  // ----------------------------------------------------------------------
  // response routing
  // ----------------------------------------------------------------------
  assign {b_idx, b_id} = i_b.id;
  assign o_b_ready     = i_b_valid ? sb_bready[b_idx] : 1'b0;

endmodule

// File: rtl/axi_wr_memory.sv
`timescale 1ns/1ns

module axi_wr_memory (
  input  logic              clk,
  input  logic              rst_n,
  input  axi_wr_pkg::aw_t   i_aw,
  input  logic              i_aw_valid,
  output logic              o_aw_ready,
  input  axi_wr_pkg::w_t    i_w,
  input  logic              i_w_valid,
  output logic              o_w_ready,
  output axi_wr_pkg::b_t    o_b,
  output logic              o_b_valid,
  input  logic              i_b_ready,
  input  axi_wr_pkg::word_t i_rd_word,
  output axi_wr_pkg::data_t o_rd_data
);

  import axi_wr_pkg::*;

  mem_state_t state;
  len_t       beat_cnt;
  word_t      base_word;
  mid_t       id_q;
  logic       err_q;
  word_t      wr_word;
  logic       aw_fire;
  logic       w_fire;

  data_t      mem [mem_words];

  assign o_aw_ready = (state == mem_idle);
  assign o_w_ready  = (state == mem_data);
  assign o_b_valid  = (state == mem_resp);

  assign aw_fire = i_aw_valid && o_aw_ready;
  assign w_fire  = i_w_valid && o_w_ready;

  // INCR only, so each beat lands on the next word
  assign wr_word = base_word + word_t'(beat_cnt);

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= mem_idle;
      beat_cnt <= '0;
    end else begin
      case (state)
        mem_idle: begin
          if (aw_fire) begin
            state    <= mem_data;
            beat_cnt <= '0;
          end
        end
        mem_data: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (i_w.last) begin
              state <= mem_resp;
            end
          end
        end
        mem_resp: begin
          if (i_b_ready) begin
            state <= mem_idle;
          end
        end
        default: state <= mem_idle;
      endcase
    end
  end

  // address, id and error flag captured with the address
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      base_word <= i_aw.addr[addr_w-1 -: word_w];
      id_q      <= i_aw.id;
      err_q     <= (i_aw.burst != burst_incr) || (i_aw.size != size_beat);
    end
  end

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (w_fire && !err_q) begin
      for (int b = 0; b < strb_w; b++) begin
        if (i_w.strb[b]) begin
          mem[wr_word][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
  end

  assign o_b.id   = id_q;
  assign o_b.resp = err_q ? resp_slverr : resp_okay;

  // observation port
  assign o_rd_data = mem[i_rd_word];

endmodule

// File: rtl/axi_wr_pkg.sv
package axi_wr_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------
  localparam int num_m     = 2;
  localparam int idx_w     = $clog2(num_m);
  localparam int addr_w    = 8;
  localparam int data_w    = 16;
  localparam int strb_w    = data_w / 8;
  localparam int id_w      = 4;
  localparam int mid_w     = idx_w + id_w;
  localparam int mem_words = 128;
  localparam int word_w    = $clog2(mem_words);

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;
  typedef logic [id_w-1:0]   id_t;
  typedef logic [mid_w-1:0]  mid_t;
  typedef logic [idx_w-1:0]  idx_t;
  typedef logic [7:0]        len_t;
  typedef logic [2:0]        size_t;
  typedef logic [1:0]        burst_t;
  typedef logic [1:0]        resp_t;
  typedef logic [word_w-1:0] word_t;

  // only 2-byte INCR beats are accepted
  localparam size_t  size_beat   = 3'd1;
  localparam burst_t burst_incr  = 2'd1;
  localparam resp_t  resp_okay   = 2'd0;
  localparam resp_t  resp_slverr = 2'd2;

  // manager-side request and response widths held in the skid buffers
  localparam int aw_req_w = $bits(id_t) + $bits(addr_t) + $bits(len_t) + $bits(size_t) +
                            $bits(burst_t);
  localparam int b_rsp_w  = $bits(id_t) + $bits(resp_t);

  // ----------------------------------------------------------------------
  // subordinate-side channels
  // ----------------------------------------------------------------------
  typedef struct packed {
    mid_t   id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_t;

  typedef struct packed {
    mid_t  id;
    resp_t resp;
  } b_t;

  typedef enum logic [1:0] {mem_idle, mem_data, mem_resp} mem_state_t;

endpackage

// File: rtl/axi_wr_subsystem.sv
`timescale 1ns/1ns

module axi_wr_subsystem (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic               [axi_wr_pkg::num_m-1:0] i_awvalid,
  input  axi_wr_pkg::addr_t  [axi_wr_pkg::num_m-1:0] i_awaddr,
  input  axi_wr_pkg::id_t    [axi_wr_pkg::num_m-1:0] i_awid,
  input  axi_wr_pkg::len_t   [axi_wr_pkg::num_m-1:0] i_awlen,
  input  axi_wr_pkg::size_t  [axi_wr_pkg::num_m-1:0] i_awsize,
  input  axi_wr_pkg::burst_t [axi_wr_pkg::num_m-1:0] i_awburst,
  output logic               [axi_wr_pkg::num_m-1:0] o_awready,
  input  logic               [axi_wr_pkg::num_m-1:0] i_wvalid,
  input  axi_wr_pkg::data_t  [axi_wr_pkg::num_m-1:0] i_wdata,
  input  axi_wr_pkg::strb_t  [axi_wr_pkg::num_m-1:0] i_wstrb,
  input  logic               [axi_wr_pkg::num_m-1:0] i_wlast,
  output logic               [axi_wr_pkg::num_m-1:0] o_wready,
  output logic               [axi_wr_pkg::num_m-1:0] o_bvalid,
  output axi_wr_pkg::id_t    [axi_wr_pkg::num_m-1:0] o_bid,
  output axi_wr_pkg::resp_t  [axi_wr_pkg::num_m-1:0] o_bresp,
  input  logic               [axi_wr_pkg::num_m-1:0] i_bready,
  input  axi_wr_pkg::word_t                          i_rd_word,
  output axi_wr_pkg::data_t                          o_rd_data
);

  import axi_wr_pkg::*;

  // arbiter to memory
  aw_t  aw;
  logic aw_valid;
  logic aw_ready;
  w_t   w;
  logic w_valid;
  logic w_ready;
  b_t   b;
  logic b_valid;
  logic b_ready;

  axi_wr_arbiter arbiter (
    .clk(clk), .rst_n(rst_n),
    .i_awvalid(i_awvalid), .i_awaddr(i_awaddr), .i_awid(i_awid), .i_awlen(i_awlen),
    .i_awsize(i_awsize), .i_awburst(i_awburst), .o_awready(o_awready),
    .i_wvalid(i_wvalid), .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wlast(i_wlast),
    .o_wready(o_wready),
    .o_bvalid(o_bvalid), .o_bid(o_bid), .o_bresp(o_bresp), .i_bready(i_bready),
    .o_aw(aw), .o_aw_valid(aw_valid), .i_aw_ready(aw_ready),
    .o_w(w), .o_w_valid(w_valid), .i_w_ready(w_ready),
    .i_b(b), .i_b_valid(b_valid), .o_b_ready(b_ready)
  );

  axi_wr_memory memory (
    .clk(clk), .rst_n(rst_n),
    .i_aw(aw), .i_aw_valid(aw_valid), .o_aw_ready(aw_ready),
    .i_w(w), .i_w_valid(w_valid), .o_w_ready(w_ready),
    .o_b(b), .o_b_valid(b_valid), .i_b_ready(b_ready),
    .i_rd_word(i_rd_word), .o_rd_data(o_rd_data)
  );

endmodule

// File: rtl/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [axi_wr_pkg::num_m-1:0] i_request,
  input  logic                         i_done,
  output logic                         o_grant_valid,
  output axi_wr_pkg::idx_t             o_grant_idx
);

  import axi_wr_pkg::*;

  logic             pick_valid;
  idx_t             pick_idx;

  // search upward from the last grant, lowest offset wins
  // only used while idle, so the holder never competes for its own grant
  always_comb begin
    idx_t cand;
    pick_valid = 1'b0;
    pick_idx   = o_grant_idx;
    for (int k = num_m; k >= 1; k--) begin
      cand = o_grant_idx + idx_t'(k);
      if (i_request[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_grant_valid <= 1'b0;
      // start one below manager 0 so that manager 0 goes first
      o_grant_idx   <= idx_t'(num_m - 1);
    end else if (o_grant_valid) begin
      if (i_done) begin
        o_grant_valid <= 1'b0;
      end
    end else if (pick_valid) begin
      o_grant_valid <= 1'b1;
      o_grant_idx   <= pick_idx;
    end
  end

endmodule

// File: rtl/skid_buffer.sv
`timescale 1ns/1ns

module skid_buffer #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_valid,
  input  logic [width-1:0] i_data,
  output logic             o_ready,
  output logic             o_valid,
  output logic [width-1:0] o_data,
  input  logic             i_ready
);

  logic             skid_valid;
  logic [width-1:0] skid_data;
  logic             up_fire;
  logic             main_free;

  // upstream ready comes straight from the skid flag register
  assign o_ready   = !skid_valid;
  assign up_fire   = i_valid && o_ready;
  // main slot can take a new item this edge
  assign main_free = !o_valid || i_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_free) begin
        o_valid    <= skid_valid || up_fire;
        skid_valid <= 1'b0;
      end else if (up_fire) begin
        // output stalled, park the incoming item
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        o_data <= skid_data;
      end else if (up_fire) begin
        o_data <= i_data;
      end
    end
    // skid slot is free whenever upstream is allowed to send
    if (o_ready) begin
      skid_data <= i_data;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f project.f --top-module axi_wr_tb \
    -o axi_wr_sim &&
  ./obj_dir/axi_wr_sim | tee /dev/stderr | grep -qF '** PASS **' &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: sim/axi_wr_assertions.sv
`timescale 1ns/1ns

module axi_wr_assertions (
  input logic            clk,
  input logic            rst_n,
  input axi_wr_pkg::aw_t i_aw,
  input logic            i_aw_valid,
  input logic            o_aw_ready,
  input axi_wr_pkg::w_t  i_w,
  input logic            i_w_valid,
  input logic            o_w_ready,
  input axi_wr_pkg::b_t  o_b,
  input logic            o_b_valid,
  input logic            i_b_ready
);

  logic addr_open;

  // an accepted address opens a burst, the last beat closes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_open <= 1'b0;
    end else if (i_aw_valid && o_aw_ready) begin
      addr_open <= 1'b1;
    end else if (i_w_valid && o_w_ready && i_w.last) begin
      addr_open <= 1'b0;
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_aw_valid && !o_aw_ready |=> i_aw_valid && $stable(i_aw))
    else $error("AW valid or payload changed before ready");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_w_valid && !o_w_ready |=> i_w_valid && $stable(i_w))
    else $error("W valid or payload changed before ready");

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b))
    else $error("B valid or payload changed before ready");

  w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
    i_w_valid |-> addr_open)
    else $error("W valid without an accepted address");

  b_in_reset: assert property (@(posedge clk) !rst_n |=> !o_b_valid)
    else $error("B valid high after a reset edge");

endmodule

bind axi_wr_memory axi_wr_assertions protocol_checks (
  .clk(clk), .rst_n(rst_n),
  .i_aw(i_aw), .i_aw_valid(i_aw_valid), .o_aw_ready(o_aw_ready),
  .i_w(i_w), .i_w_valid(i_w_valid), .o_w_ready(o_w_ready),
  .o_b(o_b), .o_b_valid(o_b_valid), .i_b_ready(i_b_ready)
);

// File: sim/axi_wr_tb.sv
`timescale 1ns/1ns

module axi_wr_tb;

  import axi_wr_pkg::*;

  // one stimulus row, start is the earliest cycle after reset
  typedef struct packed {
    idx_t        mgr;
    id_t         id;
    addr_t       addr;
    len_t        len;
    burst_t      burst;
    size_t       size;
    logic        rnd_strb;
    logic [15:0] start;
    logic [7:0]  stall;
  } row_t;

  localparam int n_rows = 12;

  logic               clk;
  logic               rst_n;
  logic   [num_m-1:0] awvalid;
  addr_t  [num_m-1:0] awaddr;
  id_t    [num_m-1:0] awid;
  len_t   [num_m-1:0] awlen;
  size_t  [num_m-1:0] awsize;
  burst_t [num_m-1:0] awburst;
  logic   [num_m-1:0] awready;
  logic   [num_m-1:0] wvalid;
  data_t  [num_m-1:0] wdata;
  strb_t  [num_m-1:0] wstrb;
  logic   [num_m-1:0] wlast;
  logic   [num_m-1:0] wready;
  logic   [num_m-1:0] bvalid;
  id_t    [num_m-1:0] bid;
  resp_t  [num_m-1:0] bresp;
  logic   [num_m-1:0] bready;
  word_t              rd_word;
  data_t              rd_data;

  row_t        rows [n_rows];
  data_t       ref_mem [mem_words];
  strb_t       ref_known [mem_words];
  int          exp_q [num_m][$];
  int          done_cyc [n_rows];
  int          got_cnt [num_m];
  int          want_cnt [num_m];
  int          resp_total;
  int          cyc;
  int          limit_cyc;
  int          value_errors;
  int          other_errors;
  logic [15:0] lfsr;

  axi_wr_subsystem axi_wr_subsystem_inst (
    .clk(clk), .rst_n(rst_n),
    .i_awvalid(awvalid), .i_awaddr(awaddr), .i_awid(awid), .i_awlen(awlen),
    .i_awsize(awsize), .i_awburst(awburst), .o_awready(awready),
    .i_wvalid(wvalid), .i_wdata(wdata), .i_wstrb(wstrb), .i_wlast(wlast),
    .o_wready(wready),
    .o_bvalid(bvalid), .o_bid(bid), .o_bresp(bresp), .i_bready(bready),
    .i_rd_word(rd_word), .o_rd_data(rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus table
  // ----------------------------------------------------------------------
  task automatic load_table();
    // same-cycle pair after reset, manager 0 wins
    rows[0]  = '{1'b0, 4'd3,  8'h00, 8'd0,  burst_incr, size_beat, 1'b0, 16'd0,   8'd0};
    rows[1]  = '{1'b1, 4'd5,  8'h80, 8'd0,  burst_incr, size_beat, 1'b0, 16'd0,   8'd0};
    // full fill, then random strobes over the same 16 words
    rows[2]  = '{1'b0, 4'd1,  8'h10, 8'd15, burst_incr, size_beat, 1'b0, 16'd10,  8'd0};
    rows[3]  = '{1'b0, 4'd2,  8'h10, 8'd15, burst_incr, size_beat, 1'b1, 16'd10,  8'd0};
    // manager 1 stalls its first response for 30 cycles
    rows[4]  = '{1'b1, 4'd6,  8'h90, 8'd3,  burst_incr, size_beat, 1'b0, 16'd10,  8'd30};
    rows[5]  = '{1'b1, 4'd7,  8'ha0, 8'd1,  burst_incr, size_beat, 1'b1, 16'd10,  8'd0};
    rows[6]  = '{1'b0, 4'd4,  8'h30, 8'd7,  burst_incr, size_beat, 1'b1, 16'd10,  8'd0};
    // FIXED burst and byte size, both rejected
    rows[7]  = '{1'b0, 4'd9,  8'h10, 8'd3,  2'd0,       size_beat, 1'b1, 16'd10,  8'd0};
    rows[8]  = '{1'b1, 4'd10, 8'h90, 8'd1,  burst_incr, 3'd0,      1'b0, 16'd10,  8'd0};
    // leaves manager 0 as the last grant
    rows[9]  = '{1'b0, 4'd11, 8'h40, 8'd0,  burst_incr, size_beat, 1'b0, 16'd200, 8'd0};
    rows[10] = '{1'b0, 4'd12, 8'h42, 8'd1,  burst_incr, size_beat, 1'b1, 16'd260, 8'd0};
    rows[11] = '{1'b1, 4'd13, 8'hb0, 8'd1,  burst_incr, size_beat, 1'b0, 16'd260, 8'd0};
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // only 2-byte INCR bursts are written
  function automatic resp_t expect_resp(input row_t rw);
    if (rw.burst == burst_incr && rw.size == size_beat) begin
      return resp_okay;
    end
    return resp_slverr;
  endfunction

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic check_b(input int row, input id_t got_id, input resp_t got_resp,
                         input id_t exp_id, input resp_t exp_resp);
    if (got_id !== exp_id || got_resp !== exp_resp) begin
      value_errors++;
      $display("Error: %0t ns: row %0d response id %h resp %h, expected id %h resp %h",
               $time, row, got_id, got_resp, exp_id, exp_resp);
    end
  endtask

  task automatic check_data(input word_t w, input data_t got, input data_t exp,
                            input strb_t known);
    data_t mask;
    for (int k = 0; k < strb_w; k++) begin
      mask[8*k +: 8] = {8{known[k]}};
    end
    if ((got & mask) !== (exp & mask)) begin
      value_errors++;
      $display("Error: %0t ns: word %0d read %h, expected %h on bytes %b",
               $time, w, got, exp, known);
    end
  endtask

  task automatic check_order(input int early, input int late);
    if (done_cyc[early] >= done_cyc[late]) begin
      other_errors++;
      $display("row %0d was answered at cycle %0d, which is not before row %0d at cycle %0d",
               early, done_cyc[early], late, done_cyc[late]);
    end
  endtask

  // ----------------------------------------------------------------------
  // manager side
  // ----------------------------------------------------------------------
  // ready is registered, so it is read at the falling edge
  task automatic wait_accept(input int m, input bit data_ch);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      taken = data_ch ? wready[m] : awready[m];
      @(negedge clk);
    end
  endtask

  task automatic drive_rows(input int m);
    data_t d;
    strb_t s;
    word_t w;
    for (int r = 0; r < n_rows; r++) begin
      if (rows[r].mgr == idx_t'(m)) begin
        while (cyc < int'(rows[r].start)) @(negedge clk);
        exp_q[m].push_back(r);
        awvalid[m] = 1'b1;
        awid[m]    = rows[r].id;
        awaddr[m]  = rows[r].addr;
        awlen[m]   = rows[r].len;
        awsize[m]  = rows[r].size;
        awburst[m] = rows[r].burst;
        wait_accept(m, 1'b0);
        awvalid[m] = 1'b0;
        for (int b = 0; b <= int'(rows[r].len); b++) begin
          d = data_t'(rand_bits(data_w));
          s = rows[r].rnd_strb ? strb_t'(rand_bits(strb_w)) : '1;
          if (expect_resp(rows[r]) == resp_okay) begin
            // beat b lands on the address word plus b
            w = rows[r].addr[addr_w-1:1] + word_t'(b);
            for (int k = 0; k < strb_w; k++) begin
              if (s[k]) begin
                ref_mem[w][8*k +: 8] = d[8*k +: 8];
                ref_known[w][k]      = 1'b1;
              end
            end
          end
          wvalid[m] = 1'b1;
          wdata[m]  = d;
          wstrb[m]  = s;
          wlast[m]  = (b == int'(rows[r].len));
          wait_accept(m, 1'b1);
        end
        wvalid[m] = 1'b0;
        wlast[m]  = 1'b0;
      end
    end
  endtask

  task automatic watch_b(input int m);
    int r;
    forever begin
      @(negedge clk);
      if (bvalid[m]) begin
        if (exp_q[m].size() == 0) begin
          other_errors++;
          $display("manager %0d received a response with no request outstanding", m);
        end else begin
          r           = exp_q[m].pop_front();
          done_cyc[r] = cyc;
          repeat (int'(rows[r].stall)) @(negedge clk);
          check_b(r, bid[m], bresp[m], rows[r].id, expect_resp(rows[r]));
          got_cnt[m]++;
          resp_total++;
        end
        bready[m] = 1'b1;
        @(negedge clk);
        bready[m] = 1'b0;
      end
    end
  endtask

  task automatic run_watchdog(input int limit);
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  endtask

  initial begin
    rst_n   = 1'b0;
    awvalid = '0;
    awaddr  = '0;
    awid    = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = '0;
    wvalid  = '0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = '0;
    bready  = '0;
    rd_word = '0;
    lfsr    = 16'd9;
    value_errors = 0;
    other_errors = 0;
    resp_total   = 0;
    limit_cyc    = 0;
    load_table();
    for (int i = 0; i < mem_words; i++) begin
      ref_known[i] = '0;
    end
    for (int r = 0; r < n_rows; r++) begin
      want_cnt[rows[r].mgr]++;
      limit_cyc += int'(rows[r].len) + 1 + int'(rows[r].start) + int'(rows[r].stall) + 50;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fork
      drive_rows(0);
      drive_rows(1);
      watch_b(0);
      watch_b(1);
      run_watchdog(limit_cyc);
    join_none

    while (resp_total < n_rows) @(negedge clk);
    // quiet period, so that a stray extra response is caught
    repeat (20) @(negedge clk);

    for (int i = 0; i < mem_words; i++) begin
      rd_word = word_t'(i);
      @(posedge clk);
      if (ref_known[i] != '0) begin
        check_data(word_t'(i), rd_data, ref_mem[i], ref_known[i]);
      end
      @(negedge clk);
    end
    for (int m = 0; m < num_m; m++) begin
      if (got_cnt[m] != want_cnt[m]) begin
        other_errors++;
        $display("manager %0d got %0d responses for %0d rows", m, got_cnt[m], want_cnt[m]);
      end
    end
    check_order(0, 1);
    check_order(11, 10);

    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
